/* hw/fusion_config.svh */
`ifndef FUSION_CONFIG_SVH
`define FUSION_CONFIG_SVH

// Acquisition boards and samples per board per kind
`define FUSION_NUM_BOARDS 2
`define FUSION_WINDOW 8

`define FUSION_HEADER_WORDS 4
`define FUSION_FRAME_WORDS (`FUSION_HEADER_WORDS + 2 * `FUSION_NUM_BOARDS * `FUSION_WINDOW)
`define FUSION_FRAME_TYPE 32'h1234abcd

// Clock period added to the nanosecond counter each cycle
`define FUSION_CLK_NS 8
`define FUSION_IRQ_CYCLES 256
`define FUSION_ADDR_W 13

// Index widths derived from the sizes above
`define FUSION_BOARD_W ((`FUSION_NUM_BOARDS > 1) ? $clog2(`FUSION_NUM_BOARDS) : 1)
`define FUSION_INDEX_W ((`FUSION_WINDOW > 1) ? $clog2(`FUSION_WINDOW) : 1)

`endif

/* hw/fusion_pkg.sv */
package fusion_pkg;

    // Frame controller states
    typedef enum logic [2:0] {
        IDLE,
        HEADER,
        TC,
        RTD,
        IRQ
    } frame_state_t;

    // Source of each output frame word
    typedef enum logic [2:0] {
        SRC_TYPE,
        SRC_SEQ,
        SRC_SEC,
        SRC_NSEC,
        SRC_TC,
        SRC_RTD
    } word_src_t;

endpackage

/* hw/rtc_counter.sv */
`timescale 1ns/1ns

`include "fusion_config.svh"

module rtc_counter (
    input  logic        clk,
    input  logic        resetn,
    output logic [31:0] sec,
    output logic [31:0] nsec
);

    localparam logic [31:0] STEP = 32'(`FUSION_CLK_NS);
    localparam logic [31:0] BILLION = 32'd1000000000;
    // Last value before the next step would reach one second
    localparam logic [31:0] NSEC_WRAP = BILLION - STEP;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            sec  <= '0;
            nsec <= '0;
        end else if (nsec >= NSEC_WRAP) begin
            sec  <= sec + 32'd1;
            nsec <= '0;
        end else begin
            nsec <= nsec + STEP;
        end
    end

    nsec_in_range: assert property (
        @(posedge clk) disable iff (!resetn)
        nsec < BILLION
    );

endmodule

/* hw/sample_buffer.sv */
`timescale 1ns/1ns

`include "fusion_config.svh"

module sample_buffer (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       sample_valid,
    output logic                       sample_ready,
    input  logic [`FUSION_BOARD_W-1:0] sample_board,
    input  logic [31:0]                sample_data,
    input  logic                       busy,
    input  logic                       rd_en,
    input  logic [`FUSION_BOARD_W-1:0] rd_board,
    input  logic [`FUSION_INDEX_W-1:0] rd_index,
    output logic [31:0]                rd_data,
    output logic                       all_full,
    input  logic                       clear
);

    localparam int BOARDS = `FUSION_NUM_BOARDS;
    localparam int WINDOW = `FUSION_WINDOW;
    localparam int DEPTH = BOARDS * WINDOW;
    localparam int MEM_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(WINDOW + 1);
    localparam logic [COUNT_W-1:0] COUNT_FULL = COUNT_W'(WINDOW);

    logic [31:0]        mem [DEPTH];
    logic [COUNT_W-1:0] count [BOARDS];
    logic [BOARDS-1:0]  board_full;
    logic               accept;
    logic [MEM_W-1:0]   wr_addr;
    logic [MEM_W-1:0]   rd_addr;

    for (genvar b = 0; b < BOARDS; b++) begin : g_board
        assign board_full[b] = count[b] == COUNT_FULL;

        // Window never overruns between clears
        window_bound: assert property (
            @(posedge clk) disable iff (!resetn)
            count[b] <= COUNT_FULL
        );
    end

    assign all_full     = &board_full;
    assign sample_ready = !busy && !board_full[sample_board];
    assign accept       = sample_valid && sample_ready;

    // Board-major layout, one window per board
    assign wr_addr = MEM_W'(sample_board) * MEM_W'(WINDOW) + MEM_W'(count[sample_board]);
    assign rd_addr = MEM_W'(rd_board) * MEM_W'(WINDOW) + MEM_W'(rd_index);

    always_ff @(posedge clk) begin
        if (!resetn || clear) begin
            for (int i = 0; i < BOARDS; i++) begin
                count[i] <= '0;
            end
        end else if (accept) begin
            count[sample_board] <= count[sample_board] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_addr] <= sample_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* hw/frame_fsm.sv */
`timescale 1ns/1ns

`include "fusion_config.svh"

module frame_fsm (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       tc_full,
    input  logic                       rtd_full,
    output logic                       busy,
    output logic                       rd_en,
    output logic [`FUSION_BOARD_W-1:0] rd_board,
    output logic [`FUSION_INDEX_W-1:0] rd_index,
    output logic                       clear,
    output logic                       frame_start,
    output logic                       word_valid,
    output fusion_pkg::word_src_t      word_src,
    output logic [`FUSION_ADDR_W-1:0]  word_addr,
    output logic                       irq
);

    import fusion_pkg::*;

    localparam int ADDR_W = `FUSION_ADDR_W;
    localparam int BOARD_W = `FUSION_BOARD_W;
    localparam int INDEX_W = `FUSION_INDEX_W;
    localparam int IRQ_W = $clog2(`FUSION_IRQ_CYCLES + 1);
    localparam logic [ADDR_W-1:0] LAST_HEADER = ADDR_W'(`FUSION_HEADER_WORDS - 1);
    localparam logic [ADDR_W-1:0] FRAME_WORDS = ADDR_W'(`FUSION_FRAME_WORDS);
    localparam logic [ADDR_W-1:0] LAST_WORD = ADDR_W'(`FUSION_FRAME_WORDS - 1);
    localparam logic [BOARD_W-1:0] LAST_BOARD = BOARD_W'(`FUSION_NUM_BOARDS - 1);
    localparam logic [INDEX_W-1:0] LAST_INDEX = INDEX_W'(`FUSION_WINDOW - 1);
    localparam logic [IRQ_W-1:0] IRQ_LAST = IRQ_W'(`FUSION_IRQ_CYCLES - 1);

    frame_state_t        state;
    word_src_t           src_sel;
    logic [ADDR_W-1:0]   word_idx;
    logic                start;
    logic                window_end;
    logic                board_end;
    logic                last_write;
    logic [IRQ_W-1:0]    irq_cnt;

    assign start      = (state == IDLE || state == IRQ) && tc_full && rtd_full;
    assign busy       = state == HEADER || state == TC || state == RTD;
    assign rd_en      = state == TC || state == RTD;
    assign window_end = rd_index == LAST_INDEX;
    assign board_end  = rd_board == LAST_BOARD;
    // Windows are released with the last read
    assign clear      = state == RTD && board_end && window_end;

    always_comb begin
        case (state)
            HEADER: begin
                unique case (word_idx[1:0])
                    2'd0: src_sel = SRC_TYPE;
                    2'd1: src_sel = SRC_SEQ;
                    2'd2: src_sel = SRC_SEC;
                    2'd3: src_sel = SRC_NSEC;
                endcase
            end
            TC:      src_sel = SRC_TC;
            default: src_sel = SRC_RTD;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state    <= IDLE;
            word_idx <= '0;
            rd_board <= '0;
            rd_index <= '0;
        end else begin
            case (state)
                IDLE:    if (start) state <= HEADER;
                HEADER:  if (word_idx == LAST_HEADER) state <= TC;
                TC:      if (board_end && window_end) state <= RTD;
                RTD:     if (board_end && window_end) state <= IRQ;
                IRQ: begin
                    // Next frame may start while the interrupt is still up
                    if (start) begin
                        state <= HEADER;
                    end else if (irq && irq_cnt == '0) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
            if (start) begin
                word_idx <= '0;
            end else if (busy) begin
                word_idx <= word_idx + 1'b1;
            end
            if (rd_en) begin
                rd_index <= window_end ? '0 : rd_index + 1'b1;
                if (window_end) begin
                    rd_board <= board_end ? '0 : rd_board + 1'b1;
                end
            end
        end
    end

    // One cycle behind, in step with registered buffer reads
    always_ff @(posedge clk) begin
        if (!resetn) begin
            word_valid  <= 1'b0;
            frame_start <= 1'b0;
            last_write  <= 1'b0;
        end else begin
            word_valid  <= busy;
            frame_start <= start;
            last_write  <= word_valid && word_addr == LAST_WORD;
        end
    end

    always_ff @(posedge clk) begin
        word_src  <= src_sel;
        word_addr <= word_idx;
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            irq     <= 1'b0;
            irq_cnt <= '0;
        end else if (last_write) begin
            irq     <= 1'b1;
            irq_cnt <= IRQ_LAST;
        end else if (irq_cnt != '0) begin
            irq_cnt <= irq_cnt - 1'b1;
        end else begin
            irq <= 1'b0;
        end
    end

    word_addr_in_frame: assert property (
        @(posedge clk) disable iff (!resetn)
        word_valid |-> word_addr < FRAME_WORDS
    );

endmodule

/* hw/frame_assembler.sv */
`timescale 1ns/1ns

`include "fusion_config.svh"

module frame_assembler (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      frame_start,
    input  logic                      word_valid,
    input  fusion_pkg::word_src_t     word_src,
    input  logic [`FUSION_ADDR_W-1:0] word_addr,
    input  logic [31:0]               rtc_sec,
    input  logic [31:0]               rtc_nsec,
    input  logic [31:0]               tc_data,
    input  logic [31:0]               rtd_data,
    output logic                      out_en,
    output logic [3:0]                out_we,
    output logic [`FUSION_ADDR_W-1:0] out_addr,
    output logic [31:0]               out_din
);

    import fusion_pkg::*;

    logic [31:0] seq;
    logic [31:0] ts_sec;
    logic [31:0] ts_nsec;
    logic [31:0] word_data;

    // First frame goes out with sequence 1
    always_ff @(posedge clk) begin
        if (!resetn) begin
            seq <= '0;
        end else if (frame_start) begin
            seq <= seq + 32'd1;
        end
    end

    // Timestamp taken once per frame
    always_ff @(posedge clk) begin
        if (frame_start) begin
            ts_sec  <= rtc_sec;
            ts_nsec <= rtc_nsec;
        end
    end

    always_comb begin
        case (word_src)
            SRC_TYPE: word_data = `FUSION_FRAME_TYPE;
            SRC_SEQ:  word_data = seq;
            SRC_SEC:  word_data = ts_sec;
            SRC_NSEC: word_data = ts_nsec;
            SRC_TC:   word_data = tc_data;
            SRC_RTD:  word_data = rtd_data;
            default:  word_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            out_en <= 1'b0;
            out_we <= 4'h0;
        end else begin
            out_en <= word_valid;
            out_we <= {4{word_valid}};
        end
    end

    always_ff @(posedge clk) begin
        if (word_valid) begin
            out_addr <= word_addr;
            out_din  <= word_data;
        end
    end

endmodule

/* hw/sensor_fusion_top.sv */
`timescale 1ns/1ns

`include "fusion_config.svh"

module sensor_fusion_top (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       tc_sample_valid,
    output logic                       tc_sample_ready,
    input  logic [`FUSION_BOARD_W-1:0] tc_sample_board,
    input  logic [31:0]                tc_sample_data,
    input  logic                       rtd_sample_valid,
    output logic                       rtd_sample_ready,
    input  logic [`FUSION_BOARD_W-1:0] rtd_sample_board,
    input  logic [31:0]                rtd_sample_data,
    output logic                       out_en,
    output logic [3:0]                 out_we,
    output logic [`FUSION_ADDR_W-1:0]  out_addr,
    output logic [31:0]                out_din,
    output logic                       irq
);

    import fusion_pkg::*;

    logic                       tc_full;
    logic                       rtd_full;
    logic                       busy;
    logic                       rd_en;
    logic [`FUSION_BOARD_W-1:0] rd_board;
    logic [`FUSION_INDEX_W-1:0] rd_index;
    logic [31:0]                tc_rd_data;
    logic [31:0]                rtd_rd_data;
    logic                       clear;
    logic                       frame_start;
    logic                       word_valid;
    word_src_t                  word_src;
    logic [`FUSION_ADDR_W-1:0]  word_addr;
    logic [31:0]                rtc_sec;
    logic [31:0]                rtc_nsec;

    rtc_counter rtc_counter_inst (
        .clk    (clk),
        .resetn (resetn),
        .sec    (rtc_sec),
        .nsec   (rtc_nsec)
    );

    // Thermocouple samples
    sample_buffer tc_buffer_inst (
        .clk          (clk),
        .resetn       (resetn),
        .sample_valid (tc_sample_valid),
        .sample_ready (tc_sample_ready),
        .sample_board (tc_sample_board),
        .sample_data  (tc_sample_data),
        .busy         (busy),
        .rd_en        (rd_en),
        .rd_board     (rd_board),
        .rd_index     (rd_index),
        .rd_data      (tc_rd_data),
        .all_full     (tc_full),
        .clear        (clear)
    );

    // RTD samples
    sample_buffer rtd_buffer_inst (
        .clk          (clk),
        .resetn       (resetn),
        .sample_valid (rtd_sample_valid),
        .sample_ready (rtd_sample_ready),
        .sample_board (rtd_sample_board),
        .sample_data  (rtd_sample_data),
        .busy         (busy),
        .rd_en        (rd_en),
        .rd_board     (rd_board),
        .rd_index     (rd_index),
        .rd_data      (rtd_rd_data),
        .all_full     (rtd_full),
        .clear        (clear)
    );

    frame_fsm frame_fsm_inst (
        .clk         (clk),
        .resetn      (resetn),
        .tc_full     (tc_full),
        .rtd_full    (rtd_full),
        .busy        (busy),
        .rd_en       (rd_en),
        .rd_board    (rd_board),
        .rd_index    (rd_index),
        .clear       (clear),
        .frame_start (frame_start),
        .word_valid  (word_valid),
        .word_src    (word_src),
        .word_addr   (word_addr),
        .irq         (irq)
    );

    frame_assembler frame_assembler_inst (
        .clk         (clk),
        .resetn      (resetn),
        .frame_start (frame_start),
        .word_valid  (word_valid),
        .word_src    (word_src),
        .word_addr   (word_addr),
        .rtc_sec     (rtc_sec),
        .rtc_nsec    (rtc_nsec),
        .tc_data     (tc_rd_data),
        .rtd_data    (rtd_rd_data),
        .out_en      (out_en),
        .out_we      (out_we),
        .out_addr    (out_addr),
        .out_din     (out_din)
    );

endmodule

/* dv/sensor_fusion_tb.sv */
`timescale 1ns/1ns

`include "fusion_config.svh"

module sensor_fusion_tb;

    localparam int BOARDS = `FUSION_NUM_BOARDS;
    localparam int WINDOW = `FUSION_WINDOW;
    localparam int PER_KIND = BOARDS * WINDOW;
    localparam int HEADER_WORDS = `FUSION_HEADER_WORDS;
    localparam int FRAME_WORDS = `FUSION_FRAME_WORDS;
    localparam int IRQ_CYCLES = `FUSION_IRQ_CYCLES;
    localparam int ADDR_W = `FUSION_ADDR_W;
    localparam int BOARD_W = `FUSION_BOARD_W;
    localparam logic [31:0] NS_STEP = 32'(`FUSION_CLK_NS);
    localparam logic [31:0] RTD_OFFSET = 32'h0010_0000;
    localparam int ROWS = 5;
    // Worst case per stream is a gap of 3 plus the transfer cycle per sample
    localparam int FILL_CYCLES = PER_KIND * 5;
    localparam int MARGIN_CYCLES = 64;
    localparam longint TIMEOUT_NS =
        longint'(ROWS * (FILL_CYCLES + FRAME_WORDS + IRQ_CYCLES + MARGIN_CYCLES) + 8) * 8;

    typedef struct packed {
        logic [3:0]         gap;
        logic [BOARD_W-1:0] board;
        logic [31:0]        data;
    } sample_t;

    logic               clk;
    logic               resetn;
    logic               tc_sample_valid;
    logic               tc_sample_ready;
    logic [BOARD_W-1:0] tc_sample_board;
    logic [31:0]        tc_sample_data;
    logic               rtd_sample_valid;
    logic               rtd_sample_ready;
    logic [BOARD_W-1:0] rtd_sample_board;
    logic [31:0]        rtd_sample_data;
    logic               out_en;
    logic [3:0]         out_we;
    logic [ADDR_W-1:0]  out_addr;
    logic [31:0]        out_din;
    logic               irq;

    // Stimulus table, one row per frame
    string       row_name [ROWS];
    logic [31:0] row_base [ROWS];
    bit          row_interleave [ROWS];
    bit          row_random_gap [ROWS];
    bit          row_hold [ROWS];

    sample_t     tc_queue [$];
    sample_t     rtd_queue [$];
    logic [31:0] model_mem [FRAME_WORDS];
    int          accepted [2][BOARDS];
    int          frames_done;
    int          word_count;
    int          irq_run;
    bit          irq_pending;
    logic [63:0] prev_stamp;
    integer      seed;

    sensor_fusion_top sensor_fusion_top_inst (
        .clk              (clk),
        .resetn           (resetn),
        .tc_sample_valid  (tc_sample_valid),
        .tc_sample_ready  (tc_sample_ready),
        .tc_sample_board  (tc_sample_board),
        .tc_sample_data   (tc_sample_data),
        .rtd_sample_valid (rtd_sample_valid),
        .rtd_sample_ready (rtd_sample_ready),
        .rtd_sample_board (rtd_sample_board),
        .rtd_sample_data  (rtd_sample_data),
        .out_en           (out_en),
        .out_we           (out_we),
        .out_addr         (out_addr),
        .out_din          (out_din),
        .irq              (irq)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic check_word(input string name, input logic [ADDR_W-1:0] addr,
                              input logic [31:0] expected, input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s word %0d: expected %h, actual %h",
                     name, addr, expected, actual);
            fail_run("frame word mismatch");
        end
    endtask

    task automatic check_we(input string name, input logic [3:0] expected,
                            input logic [3:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s write enables: expected %h, actual %h",
                     name, expected, actual);
            fail_run("write enable mismatch");
        end
    endtask

    task automatic check_count(input string name, input string what, input int expected,
                               input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED %s %s: expected %0d, actual %0d",
                     name, what, expected, actual);
            fail_run("count mismatch");
        end
    endtask

    task automatic check_irq(input string name, input int expected, input int actual);
        if (actual != expected) begin
            $display("CHECK FAILED %s irq cycles: expected %0d, actual %0d",
                     name, expected, actual);
            fail_run("irq length mismatch");
        end
    endtask

    task automatic add_row(input int r, input string name, input logic [31:0] base,
                           input bit interleave, input bit random_gap, input bit hold);
        row_name[r] = name;
        row_base[r] = base;
        row_interleave[r] = interleave;
        row_random_gap[r] = random_gap;
        row_hold[r] = hold;
    endtask

    // Sample value rule shared by drivers and expected frames
    function automatic logic [31:0] sample_value(input int r, input int kind,
                                                 input int board, input int idx);
        return row_base[r] + (kind == 1 ? RTD_OFFSET : 32'h0) + 32'(board * WINDOW + idx);
    endfunction

    function automatic logic [31:0] expected_word(input int r, input int addr);
        int offset;
        int kind;
        if (addr == 0) begin
            return `FUSION_FRAME_TYPE;
        end
        if (addr == 1) begin
            return 32'(r + 1);
        end
        offset = addr - HEADER_WORDS;
        kind = offset / PER_KIND;
        return sample_value(r, kind, (offset % PER_KIND) / WINDOW, offset % WINDOW);
    endfunction

    task automatic push_row(input int r);
        sample_t s;
        int board;
        int idx;
        for (int kind = 0; kind < 2; kind++) begin
            for (int n = 0; n < PER_KIND; n++) begin
                board = row_interleave[r] ? n % BOARDS : n / WINDOW;
                idx = row_interleave[r] ? n / BOARDS : n % WINDOW;
                s.board = BOARD_W'(board);
                s.data = sample_value(r, kind, board, idx);
                s.gap = row_random_gap[r] ? 4'($random(seed) & 3) : 4'd0;
                if (kind == 0) begin
                    tc_queue.push_back(s);
                end else begin
                    rtd_queue.push_back(s);
                end
            end
        end
    endtask

    task automatic present(input int kind, input logic valid, input sample_t s);
        if (kind == 0) begin
            tc_sample_valid = valid;
            tc_sample_board = s.board;
            tc_sample_data = s.data;
        end else begin
            rtd_sample_valid = valid;
            rtd_sample_board = s.board;
            rtd_sample_data = s.data;
        end
    endtask

    function automatic logic stream_ready(input int kind);
        return (kind == 0) ? tc_sample_ready : rtd_sample_ready;
    endfunction

    // Valid and data held until the transfer edge
    task automatic drive_stream(input int kind);
        sample_t s;
        forever begin
            if ((kind == 0 && tc_queue.size() == 0) || (kind == 1 && rtd_queue.size() == 0)) begin
                @(posedge clk);
                #1;
            end else begin
                if (kind == 0) begin
                    s = tc_queue.pop_front();
                end else begin
                    s = rtd_queue.pop_front();
                end
                repeat (int'(s.gap)) begin
                    @(posedge clk);
                    #1;
                end
                present(kind, 1'b1, s);
                @(negedge clk);
                while (!stream_ready(kind)) @(negedge clk);
                @(posedge clk);
                #1;
                present(kind, 1'b0, s);
            end
        end
    endtask

    task automatic check_frame(input int r);
        logic [31:0] nsec;
        logic [63:0] stamp;
        nsec = model_mem[3];
        stamp = {model_mem[2], nsec};
        for (int a = 0; a < FRAME_WORDS; a++) begin
            if (a != 2 && a != 3) begin
                check_word(row_name[r], ADDR_W'(a), expected_word(r, a), model_mem[a]);
            end
        end
        if (nsec % NS_STEP != 32'd0) begin
            fail_run("timestamp nanoseconds not a multiple of the clock period");
        end
        if (nsec >= 32'd1000000000) begin
            fail_run("timestamp nanoseconds reached one second");
        end
        if (stamp <= prev_stamp) begin
            fail_run("timestamp did not advance past the previous frame");
        end
        prev_stamp = stamp;
    endtask

    task automatic record_write();
        if (frames_done >= ROWS || word_count >= FRAME_WORDS) begin
            fail_run("more words written than the stimulus table produces");
        end
        check_we(row_name[frames_done], 4'hf, out_we);
        check_count(row_name[frames_done], "write address", word_count, int'(out_addr));
        // All windows complete, and nothing of the next frame taken yet
        if (word_count == 0) begin
            for (int k = 0; k < 2; k++) begin
                for (int b = 0; b < BOARDS; b++) begin
                    check_count(row_name[frames_done], "samples accepted at frame start",
                                (frames_done + 1) * WINDOW, accepted[k][b]);
                end
            end
        end
        model_mem[word_count] = out_din;
        word_count++;
    endtask

    task automatic finish_frame();
        check_count(row_name[frames_done], "frame word count", FRAME_WORDS, word_count);
        check_frame(frames_done);
        if (!irq) begin
            fail_run("irq did not rise the cycle after the last write");
        end
        frames_done++;
        word_count = 0;
        irq_pending = 1'b1;
        irq_run = 0;
    endtask

    always @(negedge clk) begin
        if (resetn) begin
            if (tc_sample_valid && tc_sample_ready) begin
                accepted[0][tc_sample_board]++;
            end
            if (rtd_sample_valid && rtd_sample_ready) begin
                accepted[1][rtd_sample_board]++;
            end
            if (out_en) begin
                record_write();
            end else if (word_count > 0) begin
                finish_frame();
            end
            // A later frame restarts the count while irq is still up
            if (irq) begin
                if (!irq_pending) begin
                    fail_run("irq high with no finished frame");
                end
                irq_run++;
            end else if (irq_pending) begin
                check_irq(row_name[frames_done - 1], IRQ_CYCLES, irq_run);
                irq_pending = 1'b0;
            end
        end
    end

    initial begin
        wait (resetn === 1'b1);
        drive_stream(0);
    end

    initial begin
        wait (resetn === 1'b1);
        drive_stream(1);
    end

    initial begin
        #(TIMEOUT_NS);
        fail_run("watchdog expired before all frames were written");
    end

    initial begin
        resetn = 1'b0;
        tc_sample_valid = 1'b0;
        tc_sample_board = '0;
        tc_sample_data = '0;
        rtd_sample_valid = 1'b0;
        rtd_sample_board = '0;
        rtd_sample_data = '0;
        seed = 32'h2e0cf070;
        frames_done = 0;
        word_count = 0;
        irq_run = 0;
        irq_pending = 1'b0;
        prev_stamp = '0;
        for (int k = 0; k < 2; k++) begin
            for (int b = 0; b < BOARDS; b++) begin
                accepted[k][b] = 0;
            end
        end
        // Rows without hold queue up behind the previous frame
        add_row(0, "in_order_idle", 32'h0000_1000, 1'b0, 1'b0, 1'b1);
        add_row(1, "interleaved_idle", 32'h0002_0000, 1'b1, 1'b0, 1'b1);
        add_row(2, "in_order_gaps", 32'h0030_0000, 1'b0, 1'b1, 1'b1);
        add_row(3, "interleaved_backpressure", 32'h0400_0000, 1'b1, 1'b1, 1'b0);
        add_row(4, "in_order_backpressure", 32'h5000_0000, 1'b0, 1'b0, 1'b0);
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;
        @(negedge clk);
        if (!tc_sample_ready || !rtd_sample_ready) begin
            fail_run("sample ready low after reset");
        end
        for (int r = 0; r < ROWS; r++) begin
            if (row_hold[r]) begin
                while (frames_done < r || irq_pending) @(negedge clk);
            end
            push_row(r);
        end
        while (frames_done < ROWS || irq_pending) @(negedge clk);
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* all.f */
+incdir+hw
hw/fusion_pkg.sv
hw/rtc_counter.sv
hw/sample_buffer.sv
hw/frame_fsm.sv
hw/frame_assembler.sv
hw/sensor_fusion_top.sv
dv/sensor_fusion_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the sensor fusion testbench with Verilator, runs it and checks the log

set -u
cd "$(dirname "$0")" || exit 1

TOP=sensor_fusion_tb
BUILD_DIR=build
LOG=sim.log

rm -rf "$BUILD_DIR"

verilator --binary --timing --assert -Wno-fatal \
    -f all.f --top-module "$TOP" -Mdir "$BUILD_DIR" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" | tee "$LOG"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "Simulation exited with an error status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Pass line missing from $LOG"
    exit 1
fi
